//--- run_sim.sh
#!/bin/sh
# Build and run the deskew testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module tb_deskew_top -Mdir "$OBJ"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/Vtb_deskew_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
  exit 1
fi

exit 0

//--- source/deskew_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module deskew_fsm
(
  input  logic                                  i_clock,
  input  logic                                  i_arst_n,
  input  logic                                  i_enable,
  input  logic                                  i_valid,
  input  logic                                  i_resync,
  input  logic [deskew_pkg::N_LANES-1:0]        i_start_of_lane,
  input  logic [deskew_pkg::NB_DELAY_COUNT-1:0] i_common_count,
  output logic                                  o_enable_counters,
  output logic [deskew_pkg::N_LANES-1:0]        o_stop_lane_counters,
  output logic                                  o_set_fifo_delay,
  output logic                                  o_write_enb,
  output logic                                  o_read_enb,
  output logic                                  o_aligned,
  output logic                                  o_skew_error
);

  import deskew_pkg::*;

  deskew_state_t        state_q;
  deskew_state_t        state_d;
  logic [N_LANES-1:0]   stop_q;
  logic [N_LANES-1:0]   new_marks;
  logic [N_LANES-1:0]   stop_lanes;
  logic                 go_search;
  logic                 measuring;
  logic                 marker_seen;
  logic                 all_stopped;
  logic                 overflow;

  // Disable or resync restarts the measurement
  assign go_search = !i_enable || i_resync;

  assign measuring = (state_q == DSK_SEARCH) || (state_q == DSK_MEASURE);

  // Markers only count on valid words during measurement
  assign new_marks = (measuring && i_valid && !go_search) ? i_start_of_lane : '0;
  assign marker_seen = |new_marks;

  // A lane stops in its own marker cycle
  assign stop_lanes = stop_q | new_marks;
  assign all_stopped = &stop_lanes;

  // Common count at the last legal step with a lane still unmarked
  assign overflow = (state_q == DSK_MEASURE)
                 && i_valid
                 && (i_common_count == SKEW_LIMIT)
                 && !all_stopped;

  always_comb
  begin
    state_d = state_q;
    if (state_q == DSK_IDLE)
    begin
      if (i_enable)
        state_d = DSK_SEARCH;
    end
    else if (go_search)
    begin
      state_d = DSK_SEARCH;
    end
    else
    begin
      case (state_q)
        DSK_SEARCH:
        begin
          if (marker_seen)
            state_d = all_stopped ? DSK_LOAD : DSK_MEASURE;
        end
        DSK_MEASURE:
        begin
          if (all_stopped)
            state_d = DSK_LOAD;
          else if (overflow)
            state_d = DSK_ERROR;
        end
        DSK_LOAD:
        begin
          state_d = DSK_ALIGNED;
        end
        DSK_ALIGNED:
        begin
          state_d = DSK_ALIGNED;
        end
        DSK_ERROR:
        begin
          state_d = DSK_ERROR;
        end
        default:
        begin
          state_d = DSK_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge i_clock or negedge i_arst_n)
  begin
    if (!i_arst_n)
      state_q <= DSK_IDLE;
    else
      state_q <= state_d;
  end

  // Sticky marker flags, held until the next search
  always_ff @(posedge i_clock or negedge i_arst_n)
  begin
    if (!i_arst_n)
      stop_q <= '0;
    else if (go_search)
      stop_q <= '0;
    else if (measuring)
      stop_q <= stop_lanes;
  end

  // Counting starts on the first marker word, which is step 0
  assign o_enable_counters = measuring
                          && !go_search
                          && ((state_q == DSK_MEASURE) || marker_seen);

  assign o_stop_lane_counters = stop_lanes;
  assign o_set_fifo_delay = (state_q == DSK_LOAD);
  assign o_write_enb = (state_q != DSK_IDLE);
  assign o_read_enb = (state_q == DSK_ALIGNED);
  assign o_aligned = (state_q == DSK_ALIGNED);
  assign o_skew_error = (state_q == DSK_ERROR);

  // Delays load once per measurement
  a_single_load_pulse : assert property (
    @(posedge i_clock) disable iff (!i_arst_n)
      o_set_fifo_delay |=> !o_set_fifo_delay
  ) else $error("deskew_fsm: set_fifo_delay held for two cycles");

  a_status_exclusive : assert property (
    @(posedge i_clock) disable iff (!i_arst_n)
      !(o_aligned && o_skew_error)
  ) else $error("deskew_fsm: aligned and skew error both high");

endmodule

`default_nettype wire

//--- source/deskew_pkg.sv
`default_nettype none

package deskew_pkg;

  // Lane geometry
  localparam int N_LANES = 4;
  localparam int NB_DATA = 66;

  // Largest absorbable skew is MAX_SKEW-1 valid words
  localparam int MAX_SKEW = 16;
  localparam int NB_DELAY_COUNT = $clog2(MAX_SKEW);

  // Flattened buses, lane 0 in the low bits
  localparam int NB_DELAY_BUS = NB_DELAY_COUNT * N_LANES;
  localparam int NB_DATA_BUS = NB_DATA * N_LANES;

  // Saturation point of every skew counter
  localparam logic [NB_DELAY_COUNT-1:0] SKEW_LIMIT = NB_DELAY_COUNT'(MAX_SKEW - 1);

  // Deskew controller states
  typedef enum logic [2:0] {
    // Out of reset, waiting for enable
    DSK_IDLE,
    // Waiting for the first alignment marker
    DSK_SEARCH,
    // Some lanes marked, others still counting
    DSK_MEASURE,
    // One cycle to load the delay lines
    DSK_LOAD,
    // Lanes leave aligned
    DSK_ALIGNED,
    // Spread too large, needs resync
    DSK_ERROR
  } deskew_state_t;

endpackage

`default_nettype wire

//--- source/deskew_top.sv
`timescale 1ns/1ps
`default_nettype none

module deskew_top
(
  input  logic                                i_clock,
  input  logic                                i_arst_n,
  input  logic                                i_enable,
  input  logic                                i_valid,
  input  logic [deskew_pkg::N_LANES-1:0]      i_resync,
  input  logic [deskew_pkg::N_LANES-1:0]      i_start_of_lane,
  input  logic [deskew_pkg::NB_DATA_BUS-1:0]  i_data,
  output logic                                o_set_fifo_delay,
  output logic [deskew_pkg::NB_DELAY_BUS-1:0] o_lane_delay,
  output logic                                o_aligned,
  output logic                                o_skew_error,
  output logic                                o_valid,
  output logic [deskew_pkg::NB_DATA_BUS-1:0]  o_data
);

  import deskew_pkg::*;

  logic [N_LANES-1:0]        stop_lane_counters;
  logic [NB_DELAY_BUS-1:0]   lane_offset;
  logic [NB_DELAY_COUNT-1:0] common_count;
  logic                      enable_counters;
  logic                      set_fifo_delay;
  logic                      write_enb;
  logic                      read_enb;
  logic                      resync_any;
  logic                      stop_common;

  // Resync on any lane restarts every lane
  assign resync_any = |i_resync;

  // Common counter runs until the last lane is marked
  assign stop_common = &stop_lane_counters;

  deskew_fsm u_deskew_fsm
  (
    .i_clock              (i_clock),
    .i_arst_n             (i_arst_n),
    .i_enable             (i_enable),
    .i_valid              (i_valid),
    .i_resync             (resync_any),
    .i_start_of_lane      (i_start_of_lane),
    .i_common_count       (common_count),
    .o_enable_counters    (enable_counters),
    .o_stop_lane_counters (stop_lane_counters),
    .o_set_fifo_delay     (set_fifo_delay),
    .o_write_enb          (write_enb),
    .o_read_enb           (read_enb),
    .o_aligned            (o_aligned),
    .o_skew_error         (o_skew_error)
  );

  skew_counter u_common_counter
  (
    .i_clock          (i_clock),
    .i_arst_n         (i_arst_n),
    .i_enable         (i_enable),
    .i_resync         (resync_any),
    .i_enable_counter (enable_counters),
    .i_stop_counter   (stop_common),
    .i_valid          (i_valid),
    .o_count          (common_count)
  );

  // One offset counter per lane
  for (genvar i = 0; i < N_LANES; i++)
  begin : g_lane_counter
    skew_counter u_skew_counter
    (
      .i_clock          (i_clock),
      .i_arst_n         (i_arst_n),
      .i_enable         (i_enable),
      .i_resync         (resync_any),
      .i_enable_counter (enable_counters),
      .i_stop_counter   (stop_lane_counters[i]),
      .i_valid          (i_valid),
      .o_count          (lane_offset[i*NB_DELAY_COUNT +: NB_DELAY_COUNT])
    );
  end

  lane_delay_bank u_lane_delay_bank
  (
    .i_clock          (i_clock),
    .i_arst_n         (i_arst_n),
    .i_valid          (i_valid),
    .i_set_fifo_delay (set_fifo_delay),
    .i_write_enb      (write_enb),
    .i_read_enb       (read_enb),
    .i_lane_offset    (lane_offset),
    .i_common_count   (common_count),
    .i_data           (i_data),
    .o_valid          (o_valid),
    .o_data           (o_data)
  );

  assign o_set_fifo_delay = set_fifo_delay;
  assign o_lane_delay = lane_offset;

endmodule

`default_nettype wire

//--- source/lane_delay_bank.sv
`timescale 1ns/1ps
`default_nettype none

module lane_delay_bank
(
  input  logic                                  i_clock,
  input  logic                                  i_arst_n,
  input  logic                                  i_valid,
  input  logic                                  i_set_fifo_delay,
  input  logic                                  i_write_enb,
  input  logic                                  i_read_enb,
  input  logic [deskew_pkg::NB_DELAY_BUS-1:0]   i_lane_offset,
  input  logic [deskew_pkg::NB_DELAY_COUNT-1:0] i_common_count,
  input  logic [deskew_pkg::NB_DATA_BUS-1:0]    i_data,
  output logic                                  o_valid,
  output logic [deskew_pkg::NB_DATA_BUS-1:0]    o_data
);

  import deskew_pkg::*;

  logic [NB_DELAY_COUNT-1:0] lane_delay [N_LANES];
  logic                      valid_q;

  for (genvar i = 0; i < N_LANES; i++)
  begin : g_lane
    // Earliest lane waits longest
    assign lane_delay[i] = i_common_count - i_lane_offset[i*NB_DELAY_COUNT +: NB_DELAY_COUNT];

    lane_delay_line u_lane_delay_line
    (
      .i_clock     (i_clock),
      .i_arst_n    (i_arst_n),
      .i_valid     (i_valid),
      .i_set_delay (i_set_fifo_delay),
      .i_delay     (lane_delay[i]),
      .i_write_enb (i_write_enb),
      .i_read_enb  (i_read_enb),
      .i_data      (i_data[i*NB_DATA +: NB_DATA]),
      .o_data      (o_data[i*NB_DATA +: NB_DATA])
    );
  end

  // Output strobe lines up with the registered lane words
  always_ff @(posedge i_clock or negedge i_arst_n)
  begin
    if (!i_arst_n)
      valid_q <= 1'b0;
    else
      valid_q <= i_valid && i_read_enb;
  end

  assign o_valid = valid_q;

endmodule

`default_nettype wire

//--- source/lane_delay_line.sv
`timescale 1ns/1ps
`default_nettype none

module lane_delay_line
(
  input  logic                                  i_clock,
  input  logic                                  i_arst_n,
  input  logic                                  i_valid,
  input  logic                                  i_set_delay,
  input  logic [deskew_pkg::NB_DELAY_COUNT-1:0] i_delay,
  input  logic                                  i_write_enb,
  input  logic                                  i_read_enb,
  input  logic [deskew_pkg::NB_DATA-1:0]        i_data,
  output logic [deskew_pkg::NB_DATA-1:0]        o_data
);

  import deskew_pkg::*;

  // Past words, shift_q[0] is the most recent stored word
  logic [NB_DATA-1:0]        shift_q [MAX_SKEW-1];
  // Tap k is the word k valid words back, tap 0 is the current word
  logic [NB_DATA-1:0]        taps [MAX_SKEW];
  logic [NB_DELAY_COUNT-1:0] delay_q;
  logic [NB_DATA-1:0]        data_q;

  always_ff @(posedge i_clock)
  begin
    if (i_valid && i_write_enb)
    begin
      shift_q[0] <= i_data;
      for (int k = 1; k < MAX_SKEW - 1; k++)
        shift_q[k] <= shift_q[k-1];
    end
  end

  always_comb
  begin
    taps[0] = i_data;
    for (int k = 1; k < MAX_SKEW; k++)
      taps[k] = shift_q[k-1];
  end

  // Delay is held from one load to the next
  always_ff @(posedge i_clock or negedge i_arst_n)
  begin
    if (!i_arst_n)
      delay_q <= '0;
    else if (i_set_delay)
      delay_q <= i_delay;
  end

  // Selected tap, registered on each valid word while aligned
  always_ff @(posedge i_clock)
  begin
    if (i_valid && i_read_enb)
      data_q <= taps[delay_q];
  end

  assign o_data = data_q;

  a_delay_in_range : assert property (
    @(posedge i_clock) disable iff (!i_arst_n)
      i_set_delay |-> (!$isunknown(i_delay) && (int'(i_delay) < MAX_SKEW))
  ) else $error("lane_delay_line: loaded delay out of range");

endmodule

`default_nettype wire

//--- source/skew_counter.sv
`timescale 1ns/1ps
`default_nettype none

module skew_counter
(
  input  logic                                  i_clock,
  input  logic                                  i_arst_n,
  input  logic                                  i_enable,
  input  logic                                  i_resync,
  input  logic                                  i_enable_counter,
  input  logic                                  i_stop_counter,
  input  logic                                  i_valid,
  output logic [deskew_pkg::NB_DELAY_COUNT-1:0] o_count
);

  import deskew_pkg::*;

  logic [NB_DELAY_COUNT-1:0] count_q;
  logic                      clear;
  logic                      advance;

  // Restart whenever the link is disabled or any lane resyncs
  assign clear = !i_enable || i_resync;

  // One step per valid word, held once stopped or saturated
  assign advance = i_enable_counter
                && i_valid
                && !i_stop_counter
                && (count_q != SKEW_LIMIT);

  always_ff @(posedge i_clock or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      count_q <= '0;
    end
    else if (clear)
    begin
      count_q <= '0;
    end
    else if (advance)
    begin
      count_q <= count_q + 1'b1;
    end
  end

  // Final value is the marker step for a lane counter
  assign o_count = count_q;

endmodule

`default_nettype wire

//--- verif/tb_deskew_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_deskew_top;

  import deskew_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int SEED = 32'h34be_3b79;
  // Marker sits at this word value on every lane
  localparam logic [NB_DATA-1:0] MARK = 66'd96;
  // Test lengths in units of 200 clock periods
  localparam int TEST_LENGTH [5] = '{1, 3, 3, 2, 3};

  logic                    i_clock;
  logic                    i_arst_n;
  logic                    i_enable;
  logic                    i_valid;
  logic [N_LANES-1:0]      i_resync;
  logic [N_LANES-1:0]      i_start_of_lane;
  logic [NB_DATA_BUS-1:0]  i_data;
  logic                    o_set_fifo_delay;
  logic [NB_DELAY_BUS-1:0] o_lane_delay;
  logic                    o_aligned;
  logic                    o_skew_error;
  logic                    o_valid;
  logic [NB_DATA_BUS-1:0]  o_data;

  string                   test_name;
  int                      errors;
  int                      tests_passed;
  int                      tests_failed;
  int                      skew [N_LANES];
  int                      idx;
  int                      bus_idx;
  int                      cur_smax;
  bit                      gaps_on;
  bit                      en_level;
  bit                      idle_test;
  bit                      error_test;
  bit                      exp_aligned;
  bit                      exp_load;
  bit                      prev_resync;
  bit                      prev_last_mark;
  logic [NB_DELAY_BUS-1:0] exp_delay;
  logic [NB_DATA-1:0]      exp_word;

  deskew_top DUT
  (
    .i_clock          (i_clock),
    .i_arst_n         (i_arst_n),
    .i_enable         (i_enable),
    .i_valid          (i_valid),
    .i_resync         (i_resync),
    .i_start_of_lane  (i_start_of_lane),
    .i_data           (i_data),
    .o_set_fifo_delay (o_set_fifo_delay),
    .o_lane_delay     (o_lane_delay),
    .o_aligned        (o_aligned),
    .o_skew_error     (o_skew_error),
    .o_valid          (o_valid),
    .o_data           (o_data)
  );

  initial
  begin
    i_clock = 1'b0;
    forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
  end

  // Deskewed word of the last valid input on every lane
  always @(posedge i_clock)
  begin
    exp_word <= NB_DATA'(bus_idx + 64 - cur_smax);
  end

  a_idle_quiet : assert property (
    @(posedge i_clock) disable iff (!i_arst_n)
      idle_test |-> !(o_aligned || o_skew_error || o_set_fifo_delay || o_valid)
  ) else
  begin
    errors++;
    $display("%s: status or strobe output went high while disabled", test_name);
  end

  a_delay_value : assert property (
    @(posedge i_clock) disable iff (!i_arst_n)
      o_set_fifo_delay |-> (o_lane_delay == exp_delay)
  ) else
  begin
    errors++;
    $display("MISMATCH %s: expected %0h, actual %0h", test_name, exp_delay, o_lane_delay);
  end

  a_load_then_aligned : assert property (
    @(posedge i_clock) disable iff (!i_arst_n)
      o_set_fifo_delay |=> o_aligned
  ) else
  begin
    errors++;
    $display("%s: o_aligned did not rise after the delay load", test_name);
  end

  a_valid_follows : assert property (
    @(posedge i_clock) disable iff (!i_arst_n)
      o_valid == $past(i_valid && exp_aligned)
  ) else
  begin
    errors++;
    $display("MISMATCH %s: expected %0b, actual %0b", test_name,
             !o_valid, o_valid);
  end

  a_no_load_on_error : assert property (
    @(posedge i_clock) disable iff (!i_arst_n)
      error_test |-> !(o_set_fifo_delay || o_aligned)
  ) else
  begin
    errors++;
    $display("%s: load pulse or alignment seen with too large a skew", test_name);
  end

  a_resync_drops : assert property (
    @(posedge i_clock) disable iff (!i_arst_n)
      (|i_resync) |=> !(o_aligned || o_skew_error)
  ) else
  begin
    errors++;
    $display("%s: status stayed high after resync", test_name);
  end

  for (genvar i = 0; i < N_LANES; i++)
  begin : g_lane_check
    a_lane_data : assert property (
      @(posedge i_clock) disable iff (!i_arst_n)
        o_valid |-> (o_data[i*NB_DATA +: NB_DATA] == exp_word)
    ) else
    begin
      errors++;
      $display("MISMATCH %s lane %0d: expected %0h, actual %0h", test_name, i,
               exp_word, o_data[i*NB_DATA +: NB_DATA]);
    end
  end

  function automatic int total_length();
    int sum;
    sum = 0;
    foreach (TEST_LENGTH[k])
      sum += TEST_LENGTH[k];
    return sum;
  endfunction

  initial
  begin
    #(total_length() * 200 * CLK_PERIOD);
    $display("Watchdog timeout, the run did not finish in time");
    $display(">>> FAIL");
    $finish;
  end

  // One clock of stimulus that returns at the falling edge
  task automatic step(input logic [N_LANES-1:0] resync);
    logic [NB_DATA-1:0] word;
    logic [N_LANES-1:0] marks;
    bit                 v;
    bit                 aligned_next;
    bit                 last_mark;
    @(posedge i_clock);
    // Expected status from the previous cycle's markers and resync
    aligned_next = !prev_resync && (exp_load || exp_aligned);
    exp_load = !prev_resync && prev_last_mark;
    exp_aligned <= aligned_next;
    v = !gaps_on || (($urandom % 4) != 0);
    marks = '0;
    last_mark = 1'b0;
    i_enable <= en_level;
    i_resync <= resync;
    i_valid <= v;
    if (v)
    begin
      for (int i = 0; i < N_LANES; i++)
      begin
        word = NB_DATA'(idx + 64 - skew[i]);
        i_data[i*NB_DATA +: NB_DATA] <= word;
        marks[i] = (word == MARK);
        // Marker of the latest lane ends the measurement
        if (marks[i] && (skew[i] == cur_smax))
          last_mark = 1'b1;
      end
      bus_idx <= idx;
      idx++;
    end
    i_start_of_lane <= marks;
    prev_resync = |resync;
    prev_last_mark = last_mark && en_level && !error_test;
    @(negedge i_clock);
  endtask

  task automatic finish_test(input int errors_before);
    if (errors == errors_before)
    begin
      tests_passed++;
      $display("test %s passed", test_name);
    end
    else
    begin
      tests_failed++;
      $display("test %s failed with %0d errors", test_name, errors - errors_before);
    end
  endtask

  task automatic resync_one_lane();
    logic [N_LANES-1:0] lane_bit;
    lane_bit = N_LANES'(1) << ($urandom % N_LANES);
    step(lane_bit);
    step('0);
  endtask

  // Streams skewed lanes from word 0 until aligned or in error
  task automatic measure(input string name, input bit gaps, input bit expect_error);
    int smin;
    int smax;
    int set_count;
    int valid_seen;
    int base;
    int lo;
    int hi;
    int errors_before;
    errors_before = errors;
    test_name = name;
    gaps_on = gaps;
    base = $urandom % 8;
    for (int i = 0; i < N_LANES; i++)
      skew[i] = expect_error ? base + ($urandom % 16) : ($urandom % MAX_SKEW);
    if (expect_error)
    begin
      lo = $urandom % N_LANES;
      hi = (lo + 1 + ($urandom % (N_LANES - 1))) % N_LANES;
      skew[lo] = base;
      skew[hi] = base + MAX_SKEW + ($urandom % 8);
    end
    smin = skew[0];
    smax = skew[0];
    foreach (skew[i])
    begin
      smin = (skew[i] < smin) ? skew[i] : smin;
      smax = (skew[i] > smax) ? skew[i] : smax;
    end
    foreach (skew[i])
      exp_delay[i*NB_DELAY_COUNT +: NB_DELAY_COUNT] = NB_DELAY_COUNT'(skew[i] - smin);
    cur_smax = smax;
    idx = 0;
    set_count = 0;
    error_test = expect_error;
    do
    begin
      step('0);
      if (o_set_fifo_delay)
        set_count++;
    end
    while (!(o_aligned || o_skew_error));
    valid_seen = 0;
    repeat (60)
    begin
      step('0);
      if (o_set_fifo_delay)
        set_count++;
      if (o_valid)
        valid_seen++;
    end
    if (expect_error)
    begin
      if (!o_skew_error)
      begin
        errors++;
        $display("%s: o_skew_error did not stay high", name);
      end
      if (set_count != 0)
      begin
        errors++;
        $display("MISMATCH %s: expected %0d, actual %0d", name, 0, set_count);
      end
    end
    else
    begin
      if (set_count != 1)
      begin
        errors++;
        $display("MISMATCH %s: expected %0d, actual %0d", name, 1, set_count);
      end
      if (valid_seen == 0)
      begin
        errors++;
        $display("%s: no output words seen while aligned", name);
      end
    end
    finish_test(errors_before);
  endtask

  initial
  begin
    int errors_before;
    void'($urandom(SEED));
    i_arst_n = 1'b0;
    i_enable = 1'b0;
    i_valid = 1'b0;
    i_resync = '0;
    i_start_of_lane = '0;
    i_data = '0;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    foreach (skew[i])
      skew[i] = 0;
    idx = 0;
    bus_idx = 0;
    cur_smax = 0;
    gaps_on = 1'b0;
    en_level = 1'b0;
    idle_test = 1'b0;
    error_test = 1'b0;
    exp_aligned = 1'b0;
    exp_load = 1'b0;
    prev_resync = 1'b0;
    prev_last_mark = 1'b0;
    exp_delay = '0;
    repeat (4) @(posedge i_clock);
    i_arst_n <= 1'b1;
    @(negedge i_clock);

    // Disabled link must stay quiet
    errors_before = errors;
    test_name = "idle_disabled";
    gaps_on = 1'b1;
    idle_test = 1'b1;
    repeat (20) step('0);
    idle_test = 1'b0;
    finish_test(errors_before);

    en_level = 1'b1;
    measure("align_random", 1'b0, 1'b0);
    resync_one_lane();
    measure("resync_aligned", 1'b1, 1'b0);
    resync_one_lane();
    measure("skew_error", 1'b1, 1'b1);
    error_test = 1'b0;
    resync_one_lane();
    measure("resync_error", 1'b1, 1'b0);

    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
source/deskew_pkg.sv
source/skew_counter.sv
source/deskew_fsm.sv
source/lane_delay_line.sv
source/lane_delay_bank.sv
source/deskew_top.sv
verif/tb_deskew_top.sv
